// ==== src/bus_split.sv ====
module bus_split
   import soc_pkg::*;
   (
   // master side
   input  logic  m_valid,
   input  addr_t m_address,
   input  data_t m_wdata,
   input  strb_t m_wstrb,
   output data_t m_rdata,
   output logic  m_ready,

   // slave requests
   output logic  mem_valid,
   output logic  uart_valid,
   output addr_t s_address,
   output data_t s_wdata,
   output strb_t s_wstrb,

   // slave responses
   input  data_t mem_rdata,
   input  logic  mem_ready,
   input  data_t uart_rdata,
   input  logic  uart_ready
   );

   logic sel_uart;

   // slave select straight from the address
   assign sel_uart = m_address[sel_bit];

   assign mem_valid  = m_valid & ~sel_uart;
   assign uart_valid = m_valid & sel_uart;

   // request payload goes to both slaves
   assign s_address = m_address;
   assign s_wdata   = m_wdata;
   assign s_wstrb   = m_wstrb;

   // response from the selected slave only
   always_comb begin
      if (sel_uart) begin
         m_rdata = uart_rdata;
         m_ready = uart_ready;
      end else begin
         m_rdata = mem_rdata;
         m_ready = mem_ready;
      end
   end

   // no clock here, so checks are deferred
   always_comb begin
      // a slave may only answer a request still held by the master
      if (m_ready === 1'b1) begin
         a_ready_valid: assert final (m_valid === 1'b1)
            else $error("ready without a pending request");
      end
   end

endmodule

// ==== src/int_mem.sv ====
module int_mem
   import soc_pkg::*;
   (
   input  logic  clk,
   input  logic  reset,

   // native bus slave
   input  logic  valid,
   input  addr_t address,
   input  data_t wdata,
   input  strb_t wstrb,
   output data_t rdata,
   output logic  ready
   );

   data_t mem [0:mem_words-1];

   logic [mem_addr_w-1:0] idx;
   logic access;

   // only the low bits index the array
   assign idx = address[mem_addr_w-1:0];

   // first cycle of a request, before ready
   assign access = valid & ~ready & ~reset;

   // one-cycle ready, drops again if valid goes away
   always_ff @(posedge clk) begin
      if (reset) begin
         ready <= 1'b0;
      end else begin
         ready <= valid & ~ready;
      end
   end

   // read returns the old word, write lands on the same edge
   always_ff @(posedge clk) begin
      if (access) begin
         rdata <= mem[idx];
         for (int i = 0; i < strb_w; i++) begin
            if (wstrb[i]) begin
               mem[idx][8*i +: 8] <= wdata[8*i +: 8];
            end
         end
      end
   end

   // master keeps the whole request until it sees ready
   a_req_hold: assert property (
      @(posedge clk) disable iff (reset)
      valid && !ready |=> valid && $stable(address) && $stable(wdata) && $stable(wstrb)
   ) else $error("request changed before memory ready");

endmodule

// ==== src/soc_pkg.sv ====
package soc_pkg;

   // bus widths
   localparam int data_w = 32;
   localparam int addr_w = 12;
   localparam int strb_w = data_w / 8;

   // address map, word addressed
   // bit 11 picks the slave: 0 memory, 1 uart
   localparam int sel_bit = 11;
   localparam int mem_addr_w = 10;
   localparam int mem_words = 2 ** mem_addr_w;

   // uart register offsets in address[1:0]
   localparam logic [1:0] uart_txdata = 2'd0;
   localparam logic [1:0] uart_status = 2'd1;
   localparam logic [1:0] uart_rxdata = 2'd2;

   // serial timing, clocks per bit
   localparam int baud_div = 8;
   localparam int half_div = baud_div / 2;
   localparam int baud_cnt_w = $clog2(baud_div);

   typedef logic [data_w-1:0] data_t;
   typedef logic [addr_w-1:0] addr_t;
   typedef logic [strb_w-1:0] strb_t;
   typedef logic [7:0] byte_t;
   typedef logic [baud_cnt_w-1:0] baud_cnt_t;
   typedef logic [2:0] bit_cnt_t;

   typedef enum logic [1:0] {
      tx_idle,
      tx_startbit,
      tx_databits,
      tx_stopbit
   } tx_state_t;

   typedef enum logic [1:0] {
      rx_idle,
      rx_startbit,
      rx_databits,
      rx_stopbit
   } rx_state_t;

endpackage

// ==== src/soc_top.sv ====
module soc_top
   import soc_pkg::*;
   (
   input  logic  clk,
   input  logic  reset,

   // host master bus
   input  logic  valid,
   input  addr_t address,
   input  data_t wdata,
   input  strb_t wstrb,
   output data_t rdata,
   output logic  ready,

   // rs232
   output logic  txd,
   input  logic  rxd
   );

   // shared slave request
   addr_t s_address;
   data_t s_wdata;
   strb_t s_wstrb;

   // memory slave
   logic  mem_valid;
   data_t mem_rdata;
   logic  mem_ready;

   // uart slave
   logic  uart_valid;
   data_t uart_rdata;
   logic  uart_ready;

   bus_split bus_split0 (
      .m_valid    (valid),
      .m_address  (address),
      .m_wdata    (wdata),
      .m_wstrb    (wstrb),
      .m_rdata    (rdata),
      .m_ready    (ready),
      .mem_valid  (mem_valid),
      .uart_valid (uart_valid),
      .s_address  (s_address),
      .s_wdata    (s_wdata),
      .s_wstrb    (s_wstrb),
      .mem_rdata  (mem_rdata),
      .mem_ready  (mem_ready),
      .uart_rdata (uart_rdata),
      .uart_ready (uart_ready)
   );

   int_mem int_mem0 (
      .clk     (clk),
      .reset   (reset),
      .valid   (mem_valid),
      .address (s_address),
      .wdata   (s_wdata),
      .wstrb   (s_wstrb),
      .rdata   (mem_rdata),
      .ready   (mem_ready)
   );

   uart uart0 (
      .clk     (clk),
      .reset   (reset),
      .valid   (uart_valid),
      .address (s_address),
      .wdata   (s_wdata),
      .wstrb   (s_wstrb),
      .rdata   (uart_rdata),
      .ready   (uart_ready),
      .txd     (txd),
      .rxd     (rxd)
   );

endmodule

// ==== src/uart.sv ====
module uart
   import soc_pkg::*;
   (
   input  logic  clk,
   input  logic  reset,

   // native bus slave
   input  logic  valid,
   input  addr_t address,
   input  data_t wdata,
   input  strb_t wstrb,
   output data_t rdata,
   output logic  ready,

   // serial line
   output logic  txd,
   input  logic  rxd
   );

   logic [1:0] reg_sel;
   logic access;
   logic wr;
   logic rd;

   logic tx_start;
   logic tx_busy;
   byte_t rx_byte;
   logic rx_done;
   byte_t rx_hold;
   logic rx_valid;

   assign reg_sel = address[1:0];
   assign access  = valid & ~ready;
   assign wr      = access & (|wstrb);
   assign rd      = access & ~(|wstrb);

   // writes while busy are acked but ignored
   assign tx_start = wr & (reg_sel == uart_txdata) & ~tx_busy;

   always_ff @(posedge clk) begin
      if (reset) begin
         ready <= 1'b0;
      end else begin
         ready <= valid & ~ready;
      end
   end

   // register read mux, sampled on the request cycle
   always_ff @(posedge clk) begin
      if (access) begin
         case (reg_sel)
            uart_status: rdata <= {{(data_w-2){1'b0}}, rx_valid, tx_busy};
            uart_rxdata: rdata <= {{(data_w-8){1'b0}}, rx_hold};
            default:     rdata <= '0;
         endcase
      end
   end

   // latest received byte, a new one overwrites
   always_ff @(posedge clk) begin
      if (rx_done) begin
         rx_hold <= rx_byte;
      end
   end

   // set by receiver, cleared when software reads the byte
   always_ff @(posedge clk) begin
      if (reset) begin
         rx_valid <= 1'b0;
      end else if (rx_done) begin
         rx_valid <= 1'b1;
      end else if (rd && reg_sel == uart_rxdata) begin
         rx_valid <= 1'b0;
      end
   end

   uart_tx uart_tx0 (
      .clk   (clk),
      .reset (reset),
      .start (tx_start),
      .data  (wdata[7:0]),
      .txd   (txd),
      .busy  (tx_busy)
   );

   uart_rx uart_rx0 (
      .clk   (clk),
      .reset (reset),
      .rxd   (rxd),
      .data  (rx_byte),
      .done  (rx_done)
   );

   // the transmitter must take every start
   a_tx_start: assert property (
      @(posedge clk) disable iff (reset)
      tx_start |=> tx_busy
   ) else $error("transmit start not accepted");

endmodule

// ==== src/uart_rx.sv ====
module uart_rx
   import soc_pkg::*;
   (
   input  logic  clk,
   input  logic  reset,
   input  logic  rxd,
   output byte_t data,
   output logic  done
   );

   logic rxd_meta;
   logic rxd_sync;
   logic rxd_prev;
   logic fall;

   rx_state_t state;
   baud_cnt_t baud_cnt;
   bit_cnt_t bit_cnt;
   byte_t shift;
   logic baud_tick;
   logic half_tick;

   // two-flop synchroniser plus one for edge detect
   always_ff @(posedge clk) begin
      if (reset) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
      end
   end

   assign fall      = rxd_prev & ~rxd_sync;
   assign baud_tick = (baud_cnt == baud_cnt_t'(baud_div - 1));
   assign half_tick = (baud_cnt == baud_cnt_t'(half_div - 1));

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= rx_idle;
         baud_cnt <= '0;
         bit_cnt  <= '0;
         done     <= 1'b0;
      end else begin
         done     <= 1'b0;
         baud_cnt <= baud_cnt + 1'b1;
         case (state)
            rx_idle: begin
               baud_cnt <= '0;
               bit_cnt  <= '0;
               if (fall) begin
                  state <= rx_startbit;
               end
            end
            // half a bit in, then every full bit lands mid-bit
            rx_startbit: begin
               if (half_tick) begin
                  baud_cnt <= '0;
                  state    <= rxd_sync ? rx_idle : rx_databits;
               end
            end
            rx_databits: begin
               if (baud_tick) begin
                  baud_cnt <= '0;
                  bit_cnt  <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7) begin
                     state <= rx_stopbit;
                  end
               end
            end
            rx_stopbit: begin
               if (baud_tick) begin
                  baud_cnt <= '0;
                  done     <= rxd_sync;
                  state    <= rx_idle;
               end
            end
            default: state <= rx_idle;
         endcase
      end
   end

   // shift in from the top, lsb arrives first
   always_ff @(posedge clk) begin
      if (state == rx_databits && baud_tick) begin
         shift <= {rxd_sync, shift[7:1]};
      end
      if (state == rx_stopbit && baud_tick && rxd_sync) begin
         data <= shift;
      end
   end

endmodule

// ==== src/uart_tx.sv ====
module uart_tx
   import soc_pkg::*;
   (
   input  logic  clk,
   input  logic  reset,
   input  logic  start,
   input  byte_t data,
   output logic  txd,
   output logic  busy
   );

   tx_state_t state;
   baud_cnt_t baud_cnt;
   bit_cnt_t bit_cnt;
   byte_t shift;
   logic baud_tick;

   assign baud_tick = (baud_cnt == baud_cnt_t'(baud_div - 1));
   assign busy = (state != tx_idle);

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= tx_idle;
         baud_cnt <= '0;
         bit_cnt  <= '0;
      end else begin
         // free running within a frame, parked at 0 when idle
         if (state == tx_idle || baud_tick) begin
            baud_cnt <= '0;
         end else begin
            baud_cnt <= baud_cnt + 1'b1;
         end
         case (state)
            tx_idle: begin
               bit_cnt <= '0;
               if (start) begin
                  state <= tx_startbit;
               end
            end
            tx_startbit: begin
               if (baud_tick) begin
                  state <= tx_databits;
               end
            end
            tx_databits: begin
               if (baud_tick) begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7) begin
                     state <= tx_stopbit;
                  end
               end
            end
            tx_stopbit: begin
               if (baud_tick) begin
                  state <= tx_idle;
               end
            end
            default: state <= tx_idle;
         endcase
      end
   end

   // lsb first, next bit moves down at each bit boundary
   always_ff @(posedge clk) begin
      if (state == tx_idle && start) begin
         shift <= data;
      end else if (state == tx_databits && baud_tick) begin
         shift <= {1'b0, shift[7:1]};
      end
   end

   always_comb begin
      case (state)
         tx_startbit: txd = 1'b0;
         tx_databits: txd = shift[0];
         default:     txd = 1'b1;
      endcase
   end

endmodule

// ==== tests/tb_soc.sv ====
module tb_soc
   import soc_pkg::*;
   ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int bus_timeout = 16;
   localparam int rx_poll_limit = 200;
   localparam int quiet_polls = 6 * baud_div;
   localparam int mem_slots = 64;

   logic clk;
   logic reset;
   logic valid;
   addr_t address;
   data_t wdata;
   strb_t wstrb;
   data_t rdata;
   logic ready;
   logic txd;

   integer seed;
   int pass_count;
   int fail_count;
   int late_count;
   int first_fail;
   addr_t a;
   data_t d;
   data_t rd;
   strb_t s;
   byte_t tx_b;
   byte_t rx_b;
   logic heard;
   data_t model [int];

   // serial line looped back into the receiver
   soc_top dut_i (
      .clk     (clk),
      .reset   (reset),
      .valid   (valid),
      .address (address),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .rdata   (rdata),
      .ready   (ready),
      .txd     (txd),
      .rxd     (txd)
   );

   always #2 clk = ~clk;

   task automatic end_run();
      $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   endtask

   task automatic check_word(input data_t got, input data_t exp, input string what);
      if (got === exp) begin
         pass_count++;
      end else begin
         fail_count++;
         $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_byte(input byte_t got, input byte_t exp, input string what);
      if (got === exp) begin
         pass_count++;
      end else begin
         fail_count++;
         $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got === exp) begin
         pass_count++;
      end else begin
         fail_count++;
         $display("MISMATCH at %0t ns: %s, got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic report_test(input int num, input string name, input int fails_before);
      if (fail_count == fails_before) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: FAILED (%0d errors)", num, name, fail_count - fails_before);
      end
   endtask

   // one request, held until ready, latency checked on every access
   task automatic drive_request(input addr_t addr, input data_t data, input strb_t strb,
                                output data_t rsp);
      int n;
      @(negedge clk);
      valid = 1'b1;
      address = addr;
      wdata = data;
      wstrb = strb;
      n = 0;
      while (ready !== 1'b1 && n < bus_timeout) begin
         @(negedge clk);
         n++;
      end
      if (ready !== 1'b1) begin
         fail_count++;
         $display("ERROR at %0t ns: slave never answered the request to %h", $time, addr);
         end_run();
      end else begin
         if (n != 1) begin
            fail_count++;
            late_count++;
            $display("ERROR at %0t ns: ready came %0d cycles after valid at %h instead of 1",
                     $time, n, addr);
         end
         rsp = rdata;
         // request stays up through the rising edge that takes ready
         @(negedge clk);
         valid = 1'b0;
         wstrb = '0;
      end
   endtask

   task automatic bus_write(input addr_t addr, input data_t data, input strb_t strb);
      data_t ignored;
      drive_request(addr, data, strb, ignored);
   endtask

   task automatic bus_read(input addr_t addr, output data_t data);
      drive_request(addr, data_t'($random(seed)), '0, data);
   endtask

   function automatic addr_t uart_reg(input logic [1:0] offset);
      addr_t r;
      r = '0;
      r[sel_bit] = 1'b1;
      r[1:0] = offset;
      return r;
   endfunction

   // bit 10 is above the memory index, so it aliases
   function automatic addr_t mem_addr(input int idx);
      addr_t r;
      r = '0;
      r[mem_addr_w-1:0] = idx[mem_addr_w-1:0];
      r[mem_addr_w] = $random(seed);
      return r;
   endfunction

   task automatic store_model(input int idx, input data_t data, input strb_t strb);
      data_t w;
      w = model[idx];
      for (int i = 0; i < strb_w; i++) begin
         if (strb[i]) begin
            w[8*i +: 8] = data[8*i +: 8];
         end
      end
      model[idx] = w;
   endtask

   // poll status until rx valid, then fetch the byte
   task automatic wait_rx_byte(output byte_t b);
      data_t st;
      data_t word;
      int polls;
      polls = 0;
      st = '0;
      while (st[1] !== 1'b1 && polls < rx_poll_limit) begin
         bus_read(uart_reg(uart_status), st);
         polls++;
      end
      if (st[1] !== 1'b1) begin
         fail_count++;
         $display("ERROR at %0t ns: no byte came back on the serial loopback", $time);
         end_run();
      end else begin
         bus_read(uart_reg(uart_rxdata), word);
         b = word[7:0];
      end
   endtask

   task automatic random_mem_access(input string what);
      data_t got;
      int idx;
      idx = $unsigned($random(seed)) % mem_slots;
      d = $random(seed);
      s = $random(seed);
      if (s == '0) begin
         s = 4'b0001;
      end
      bus_write(mem_addr(idx), d, s);
      store_model(idx, d, s);
      if ($random(seed) & 1) begin
         idx = $unsigned($random(seed)) % mem_slots;
         bus_read(mem_addr(idx), got);
         check_word(got, model[idx], $sformatf("%s word %0d", what, idx));
      end
   endtask

   initial begin
      seed = 32'hc948;
      pass_count = 0;
      fail_count = 0;
      late_count = 0;
      clk = 1'b0;
      reset = 1'b1;
      valid = 1'b0;
      address = '0;
      wdata = '0;
      wstrb = '0;
      repeat (4) @(negedge clk);
      reset = 1'b0;

      first_fail = fail_count;
      @(negedge clk);
      check_bit(ready, 1'b0, "ready after reset");
      check_bit(txd, 1'b1, "txd after reset");
      bus_read(uart_reg(uart_status), rd);
      check_word(rd, '0, "status after reset");
      report_test(1, "reset state", first_fail);

      // known contents first, so partial writes compare cleanly
      first_fail = fail_count;
      for (int i = 0; i < mem_slots; i++) begin
         a = mem_addr(i);
         bus_write(a, {a, 8'hc3, ~a}, 4'b1111);
         model[i] = {a, 8'hc3, ~a};
      end
      for (int i = 0; i < 200; i++) begin
         random_mem_access("memory");
      end
      report_test(2, "memory strobes", first_fail);

      first_fail = fail_count;
      for (int i = 0; i < 8; i++) begin
         tx_b = $random(seed);
         bus_write(uart_reg(uart_txdata), {24'h0, tx_b}, 4'b0001);
         wait_rx_byte(rx_b);
         check_byte(rx_b, tx_b, "loopback byte");
         bus_read(uart_reg(uart_status), rd);
         check_bit(rd[1], 1'b0, "rx valid after data read");
         check_bit(txd, 1'b1, "txd after frame");
      end
      report_test(4, "serial loopback", first_fail);

      first_fail = fail_count;
      tx_b = $random(seed);
      bus_write(uart_reg(uart_txdata), {24'h0, tx_b}, 4'b0001);
      bus_read(uart_reg(uart_status), rd);
      check_bit(rd[0], 1'b1, "busy after transmit write");
      bus_write(uart_reg(uart_txdata), {24'h0, ~tx_b}, 4'b0001);
      wait_rx_byte(rx_b);
      check_byte(rx_b, tx_b, "first byte while busy");
      // a second frame would land well within this window
      heard = 1'b0;
      for (int i = 0; i < quiet_polls; i++) begin
         bus_read(uart_reg(uart_status), rd);
         heard = heard | rd[1];
      end
      check_bit(heard, 1'b0, "dropped byte arrived");
      report_test(5, "write while busy", first_fail);

      first_fail = fail_count;
      tx_b = $random(seed);
      bus_write(uart_reg(uart_txdata), {24'h0, tx_b}, 4'b0001);
      for (int i = 0; i < 24; i++) begin
         random_mem_access("memory during tx");
      end
      wait_rx_byte(rx_b);
      check_byte(rx_b, tx_b, "byte after memory traffic");
      report_test(6, "traffic during tx", first_fail);

      if (late_count == 0) begin
         $display("test 3 ready latency: ok");
      end else begin
         $display("test 3 ready latency: FAILED (%0d errors)", late_count);
      end
      end_run();
   end

endmodule

// ==== verilog.f ====
src/soc_pkg.sv
src/bus_split.sv
src/int_mem.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart.sv
src/soc_top.sv
tests/tb_soc.sv
